/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = rv_core_tb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* rtl/rv_alu.sv */
`default_nettype none

module rv_alu
    import rv_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    input  branch_e branch,
    output word_t   result,
    output logic    taken
);

    logic eq;
    logic lt_s;
    logic lt_u;

    // shared compare for slt and the branch conditions
    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << b[4:0];
            ALU_SLT:    result = {31'b0, lt_s};
            ALU_SLTU:   result = {31'b0, lt_u};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> b[4:0];
            ALU_SRA:    result = word_t'($signed(a) >>> b[4:0]);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // --------------------------------------------------
    // branch condition
    always_comb begin
        case (branch)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            default: taken = 1'b0;  // not a branch
        endcase
    end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`default_nettype none

module rv_core
    import rv_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_we,
    input  word_t     dmem_rdata,
    output logic      retire_valid,
    output word_t     retire_pc,
    output reg_addr_t retire_rd,
    output word_t     retire_wdata,
    output logic      halt
);

    word_t       pc;
    logic        stall, flush, kill, retire_ebreak;
    fwd_sel_e    fwd_a, fwd_b;
    // decode
    logic        valid_d;
    word_t       d_instr, d_pc, d_imm, d_rdata1, d_rdata2;
    reg_addr_t   d_rs1, d_rs2, d_rd;
    alu_op_e     d_alu_op;
    branch_e     d_branch;
    result_src_e d_result_src;
    logic        d_use_imm, d_reg_we, d_mem_re, d_mem_we, d_jump, d_uses_rs1, d_uses_rs2;
    logic        d_ebreak;
    // execute
    logic        valid_e;
    word_t       e_pc, e_imm, e_rdata1, e_rdata2, e_op_a, e_src2, e_alu_res, e_result;
    reg_addr_t   e_rs1, e_rs2, e_rd;
    alu_op_e     e_alu_op;
    branch_e     e_branch;
    result_src_e e_result_src;
    logic        e_use_imm, e_reg_we, e_mem_re, e_mem_we, e_jump, e_ebreak, e_alu_taken, e_taken;
    // memory
    logic        valid_m;
    word_t       m_pc, m_result, m_wdata;
    reg_addr_t   m_rd;
    result_src_e m_result_src;
    logic        m_reg_we, m_mem_we, m_ebreak;
    // writeback
    logic        valid_w;
    word_t       w_pc, w_result, w_rdata, w_value;
    reg_addr_t   w_rd;
    result_src_e w_result_src;
    logic        w_reg_we, w_ebreak, w_we;

    assign kill = halt || retire_ebreak;  // stop everything younger than ebreak

    // --------------------------------------------------
    // fetch
    assign imem_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) pc <= RESET_PC;
        else if (kill) pc <= pc;
        else if (e_taken) pc <= e_pc + e_imm;  // branch / jal target
        else if (!stall) pc <= pc + 32'd4;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) valid_d <= 1'b0;
        else if (kill || flush) valid_d <= 1'b0;
        else if (!stall) valid_d <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            d_instr <= imem_data;
            d_pc    <= pc;
        end
    end

    // --------------------------------------------------
    // decode
    rv_decoder u_decoder (
        .instr(d_instr), .rs1(d_rs1), .rs2(d_rs2), .rd(d_rd), .imm(d_imm),
        .alu_op(d_alu_op), .branch(d_branch), .result_src(d_result_src),
        .use_imm(d_use_imm), .reg_we(d_reg_we), .mem_re(d_mem_re), .mem_we(d_mem_we),
        .jump(d_jump), .uses_rs1(d_uses_rs1), .uses_rs2(d_uses_rs2), .is_ebreak(d_ebreak)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst(rst), .raddr1(d_rs1), .raddr2(d_rs2), .waddr(w_rd),
        .wdata(w_value), .we(w_we), .rdata1(d_rdata1), .rdata2(d_rdata2)
    );

    rv_hazard_unit u_hazard (
        .rs1_d(d_rs1), .rs2_d(d_rs2), .rs1_e(e_rs1), .rs2_e(e_rs2),
        .rd_e(e_rd), .rd_m(m_rd), .rd_w(w_rd),
        .uses_rs1_d(valid_d && d_uses_rs1), .uses_rs2_d(valid_d && d_uses_rs2),
        .we_e(valid_e && e_reg_we), .load_e(valid_e && e_mem_re),
        .we_m(valid_m && m_reg_we), .we_w(w_we), .taken_e(e_taken),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall), .flush(flush)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) valid_e <= 1'b0;
        else valid_e <= valid_d && !(kill || flush || stall);  // stall leaves a bubble
    end

    always_ff @(posedge clk) begin
        e_pc         <= d_pc;
        e_imm        <= d_imm;
        e_rdata1     <= d_rdata1;
        e_rdata2     <= d_rdata2;
        e_rs1        <= d_rs1;
        e_rs2        <= d_rs2;
        e_rd         <= d_rd;
        e_alu_op     <= d_alu_op;
        e_branch     <= d_branch;
        e_result_src <= d_result_src;
        e_use_imm    <= d_use_imm;
        e_reg_we     <= d_reg_we;
        e_mem_re     <= d_mem_re;
        e_mem_we     <= d_mem_we;
        e_jump       <= d_jump;
        e_ebreak     <= d_ebreak;
    end

    // --------------------------------------------------
    // execute
    assign w_value = (w_result_src == RES_MEM) ? w_rdata : w_result;

    always_comb begin
        case (fwd_a)
            FWD_MEM: e_op_a = m_result;
            FWD_WB:  e_op_a = w_value;
            default: e_op_a = e_rdata1;
        endcase
        case (fwd_b)
            FWD_MEM: e_src2 = m_result;
            FWD_WB:  e_src2 = w_value;
            default: e_src2 = e_rdata2;
        endcase
    end

    rv_alu u_alu (
        .a(e_op_a), .b(e_use_imm ? e_imm : e_src2), .op(e_alu_op), .branch(e_branch),
        .result(e_alu_res), .taken(e_alu_taken)
    );

    assign e_result = (e_result_src == RES_PC4) ? e_pc + 32'd4 : e_alu_res;
    assign e_taken  = valid_e && (e_jump || e_alu_taken);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) valid_m <= 1'b0;
        else valid_m <= valid_e && !kill;
    end

    always_ff @(posedge clk) begin
        m_pc         <= e_pc;
        m_result     <= e_result;
        m_wdata      <= e_src2;  // forwarded store data
        m_rd         <= e_rd;
        m_result_src <= e_result_src;
        m_reg_we     <= e_reg_we;
        m_mem_we     <= e_mem_we;
        m_ebreak     <= e_ebreak;
    end

    // --------------------------------------------------
    // memory
    assign dmem_addr  = m_result;
    assign dmem_wdata = m_wdata;
    assign dmem_we    = valid_m && m_mem_we && !kill;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) valid_w <= 1'b0;
        else valid_w <= valid_m && !kill;
    end

    always_ff @(posedge clk) begin
        w_pc         <= m_pc;
        w_result     <= m_result;
        w_rdata      <= dmem_rdata;
        w_rd         <= m_rd;
        w_result_src <= m_result_src;
        w_reg_we     <= m_reg_we;
        w_ebreak     <= m_ebreak;
    end

    // --------------------------------------------------
    // writeback and retire
    assign w_we          = valid_w && w_reg_we;
    assign retire_ebreak = valid_w && w_ebreak;
    assign retire_valid  = valid_w;
    assign retire_pc     = w_pc;
    assign retire_rd     = w_we ? w_rd : '0;
    assign retire_wdata  = (retire_rd != '0) ? w_value : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) halt <= 1'b0;
        else if (retire_ebreak) halt <= 1'b1;  // sticky until reset
    end

endmodule

`default_nettype wire

/* rtl/rv_decoder.sv */
`default_nettype none

module rv_decoder
    import rv_pkg::*;
(
    input  word_t       instr,
    output reg_addr_t   rs1,
    output reg_addr_t   rs2,
    output reg_addr_t   rd,
    output word_t       imm,
    output alu_op_e     alu_op,
    output branch_e     branch,
    output result_src_e result_src,
    output logic        use_imm,
    output logic        reg_we,
    output logic        mem_re,
    output logic        mem_we,
    output logic        jump,
    output logic        uses_rs1,
    output logic        uses_rs2,
    output logic        is_ebreak
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_e    arith_op;   // op / op-imm operation from funct fields
    logic       arith_ok;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // --------------------------------------------------
    // funct3/funct7 to ALU operation
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase

        arith_ok = 1'b1;
        if (opcode == OPC_OP) begin
            arith_ok = (funct7 == 7'b0000000) ||
                       (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        end else if (funct3 == 3'b001) begin
            arith_ok = (funct7 == 7'b0000000);  // slli
        end else if (funct3 == 3'b101) begin
            arith_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end
    end

    // --------------------------------------------------
    // unknown encodings fall out as no-ops
    always_comb begin
        imm        = '0;
        alu_op     = ALU_ADD;
        branch     = BR_NONE;
        result_src = RES_ALU;
        use_imm    = 1'b0;
        reg_we     = 1'b0;
        mem_re     = 1'b0;
        mem_we     = 1'b0;
        jump       = 1'b0;
        uses_rs1   = 1'b0;
        uses_rs2   = 1'b0;
        is_ebreak  = 1'b0;

        case (opcode)
            OPC_OP: begin
                if (arith_ok) begin
                    alu_op   = arith_op;
                    reg_we   = 1'b1;
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (arith_ok) begin
                    alu_op   = arith_op;
                    imm      = imm_i;
                    use_imm  = 1'b1;
                    reg_we   = 1'b1;
                    uses_rs1 = 1'b1;
                end
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS_B;
                imm     = imm_u;
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  branch = BR_BEQ;
                    3'b001:  branch = BR_BNE;
                    3'b100:  branch = BR_BLT;
                    3'b101:  branch = BR_BGE;
                    3'b110:  branch = BR_BLTU;
                    3'b111:  branch = BR_BGEU;
                    default: branch = BR_NONE;
                endcase
                uses_rs1 = (branch != BR_NONE);
                uses_rs2 = (branch != BR_NONE);
            end
            OPC_JAL: begin
                imm        = imm_j;
                jump       = 1'b1;
                reg_we     = 1'b1;
                result_src = RES_PC4;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin  // lw only
                    imm        = imm_i;
                    use_imm    = 1'b1;
                    reg_we     = 1'b1;
                    mem_re     = 1'b1;
                    result_src = RES_MEM;
                    uses_rs1   = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin  // sw only
                    imm      = imm_s;
                    use_imm  = 1'b1;
                    mem_we   = 1'b1;
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                end
            end
            OPC_SYSTEM: is_ebreak = (instr == INSTR_EBREAK);
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/rv_hazard_unit.sv */
`default_nettype none

module rv_hazard_unit
    import rv_pkg::*;
(
    input  reg_addr_t rs1_d,
    input  reg_addr_t rs2_d,
    input  reg_addr_t rs1_e,
    input  reg_addr_t rs2_e,
    input  reg_addr_t rd_e,
    input  reg_addr_t rd_m,
    input  reg_addr_t rd_w,
    input  logic      uses_rs1_d,
    input  logic      uses_rs2_d,
    input  logic      we_e,
    input  logic      load_e,
    input  logic      we_m,
    input  logic      we_w,
    input  logic      taken_e,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b,
    output logic      stall,
    output logic      flush
);

    logic load_hit;

    // youngest producer wins
    function automatic fwd_sel_e fwd_for(input reg_addr_t rs,
                                         input reg_addr_t rdm, input logic wem,
                                         input reg_addr_t rdw, input logic wew);
        fwd_sel_e sel;
        if (wem && rdm != '0 && rdm == rs) sel = FWD_MEM;
        else if (wew && rdw != '0 && rdw == rs) sel = FWD_WB;
        else sel = FWD_RF;
        return sel;
    endfunction

    assign fwd_a = fwd_for(rs1_e, rd_m, we_m, rd_w, we_w);
    assign fwd_b = fwd_for(rs2_e, rd_m, we_m, rd_w, we_w);

    // --------------------------------------------------
    // load result only exists once the load is in memory stage
    assign load_hit = load_e && we_e && rd_e != '0 &&
                      ((uses_rs1_d && rs1_d == rd_e) || (uses_rs2_d && rs2_d == rd_e));

    assign flush = taken_e;
    assign stall = load_hit && !taken_e;  // flush wins over stall

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;      // data word, address or instruction
    typedef logic [4:0]  reg_addr_t;  // register index

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } branch_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4   // link value of jal
    } result_src_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // --------------------------------------------------
    // opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam word_t INSTR_EBREAK = 32'h0010_0073;  // full encoding

endpackage

`default_nettype wire

/* rtl/rv_regfile.sv */
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  logic      we,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write shows through to the read
    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0) value = '0;
        else if (we && addr == waddr) value = wdata;
        else value = regs[addr];
        return value;
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

`default_nettype wire

/* src.f */
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_hazard_unit.sv
rtl/rv_core.sv
verification/rv_core_sva.sv
verification/rv_core_tb.sv

/* verification/rv_core_sva.sv */
`default_nettype none

module rv_core_sva (
    input logic        clk,
    input logic        rst,
    input logic [31:0] imem_addr,
    input logic        dmem_we,
    input logic        retire_valid,
    input logic [4:0]  retire_rd,
    input logic [31:0] retire_wdata,
    input logic        halt
);

    // quiet during reset and the first cycle out of it
    reset_quiet: assert property (@(posedge clk) (rst || $fell(rst)) |->
                                  (!dmem_we && !retire_valid))
        else $error("dmem_we or retire_valid high around reset");

    aligned_fetch: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // --------------------------------------------------
    // halt only clears through reset
    halt_sticky: assert property (@(posedge clk) halt |=> (halt || rst))
        else $error("halt dropped without reset");

    rd0_no_data: assert property (@(posedge clk)
                                  (retire_valid && retire_rd == 5'd0) |-> retire_wdata == 32'd0)
        else $error("retire_wdata nonzero with retire_rd of zero");

endmodule

bind rv_core rv_core_sva u_sva (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .dmem_we(dmem_we),
    .retire_valid(retire_valid), .retire_rd(retire_rd),
    .retire_wdata(retire_wdata), .halt(halt)
);

`default_nettype wire

/* verification/rv_core_tb.sv */
`default_nettype none

module rv_core_tb;

    localparam int NUM_PROGS  = 20;
    localparam int MAX_LEN    = 48;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int MAX_CYCLES = NUM_PROGS * (MAX_LEN * 3 + 20);

    localparam logic [6:0]  OP_REG   = 7'b0110011;
    localparam logic [6:0]  OP_IMM   = 7'b0010011;
    localparam logic [6:0]  OP_LUI   = 7'b0110111;
    localparam logic [6:0]  OP_BR    = 7'b1100011;
    localparam logic [6:0]  OP_JAL   = 7'b1101111;
    localparam logic [6:0]  OP_LOAD  = 7'b0000011;
    localparam logic [6:0]  OP_STORE = 7'b0100011;
    localparam logic [31:0] EBREAK   = 32'h0010_0073;

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
    logic        dmem_we, retire_valid, halt;
    logic [31:0] retire_pc, retire_wdata;
    logic [4:0]  retire_rd;

    logic [31:0] imem       [0:IMEM_WORDS-1];
    logic [31:0] dmem       [0:DMEM_WORDS-1];
    logic [31:0] model_dmem [0:DMEM_WORDS-1];
    logic [31:0] exp_pc    [$];
    logic [4:0]  exp_rd    [$];
    logic [31:0] exp_wdata [$];
    logic [31:0] rng_state;
    int          retired;
    int          err_retire, err_mem, err_other;
    int          cycles = 0;

    rv_core #(.RESET_PC(32'h0000_0000)) DUT (
        .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_wdata(retire_wdata), .halt(halt)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we) dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    // --------------------------------------------------
    // random numbers and program generation
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic int build_program();
        logic [31:0] r;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        int          len;
        len = 8 + int'(next_rand() % 32'd41);  // ebreak included
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 32'h0000_0013 | (32'(i) << 20);  // addi x0, x0, i padding
        end
        for (int i = 0; i < len - 1; i++) begin
            r   = next_rand();
            rd  = {2'b00, r[10:8]};  // only x0..x7 for many dependencies
            rs1 = {2'b00, r[13:11]};
            rs2 = {2'b00, r[16:14]};
            f3  = r[19:17];
            imm = r[31:20];
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                    imem[i] = {(r[7] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0000000,
                               rs2, rs1, f3, rd, OP_REG};
                end
                4'd5, 4'd6, 4'd7, 4'd8: begin
                    if (f3 == 3'd1) imm = {7'b0000000, r[24:20]};
                    else if (f3 == 3'd5) imm = {1'b0, r[7], 5'b00000, r[24:20]};
                    imem[i] = {imm, rs1, f3, rd, OP_IMM};
                end
                4'd9: imem[i] = {r[31:12], rd, OP_LUI};
                4'd10, 4'd11: begin
                    f3 = r[19:17] % 3'd6;
                    if (f3 > 3'd1) f3 = f3 + 3'd2;  // skip the two unused codes
                    boff = 13'(4 * (1 + int'(next_rand() % 32'(len - 1 - i))));
                    imem[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OP_BR};
                end
                4'd12: begin
                    joff = 21'(4 * (1 + int'(next_rand() % 32'(len - 1 - i))));
                    imem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OP_JAL};
                end
                4'd13, 4'd14: begin
                    imm = {6'b000000, r[23:20], 2'b00};  // 16 words so loads hit stores
                    imem[i] = {imm, 5'd0, 3'b010, rd, OP_LOAD};
                end
                default: begin
                    imm = {6'b000000, r[23:20], 2'b00};
                    imem[i] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OP_STORE};
                end
            endcase
        end
        imem[len-1] = EBREAK;
        return len;
    endfunction

    // --------------------------------------------------
    // instruction-set reference model
    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic [31:0]        r;
        sa = a;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) r = sa >>> b[4:0];
                else r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic int run_model();
        logic [31:0] x [0:31];
        logic [31:0] pc, ins, a, b, res, tgt, addr;
        logic [31:0] imm_i, imm_s, imm_b, imm_j;
        logic [4:0]  rd;
        logic        wr;
        int          n;
        for (int i = 0; i < 32; i++) x[i] = '0;
        pc = '0;
        n  = 0;
        exp_pc.delete();
        exp_rd.delete();
        exp_wdata.delete();
        while (n < IMEM_WORDS) begin
            ins   = imem[pc[7:2]];
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            rd    = ins[11:7];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            wr    = 1'b0;
            res   = '0;
            tgt   = pc + 32'd4;
            case (ins[6:0])
                OP_REG: begin
                    wr  = 1'b1;
                    res = alu_result(ins[14:12], ins[30], a, b);
                end
                OP_IMM: begin
                    wr  = 1'b1;
                    res = alu_result(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
                end
                OP_LUI: begin
                    wr  = 1'b1;
                    res = {ins[31:12], 12'h000};
                end
                OP_BR: if (branch_taken(ins[14:12], a, b)) tgt = pc + imm_b;
                OP_JAL: begin
                    wr  = 1'b1;
                    res = pc + 32'd4;
                    tgt = pc + imm_j;
                end
                OP_LOAD: begin
                    wr   = 1'b1;
                    addr = a + imm_i;
                    res  = model_dmem[addr[7:2]];
                end
                OP_STORE: begin
                    addr = a + imm_s;
                    model_dmem[addr[7:2]] = b;
                end
                default: ;  // ebreak
            endcase
            if (!wr) rd = 5'd0;
            if (rd != 5'd0) x[rd] = res;
            exp_pc.push_back(pc);
            exp_rd.push_back(rd);
            exp_wdata.push_back((rd != 5'd0) ? res : 32'd0);
            n++;
            if (ins == EBREAK) break;
            pc = tgt;
        end
        return n;
    endfunction

    // --------------------------------------------------
    // retire checker sampling at the falling edge
    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            assert (!halt) else begin
                $display("instruction retired at pc %h while the core was halted", retire_pc);
                err_other++;
            end
            assert (retired < exp_pc.size()) else begin
                $display("unexpected retire at pc %h after the program ended", retire_pc);
                err_other++;
            end
            if (retired < exp_pc.size()) begin
                assert (retire_pc == exp_pc[retired]) else begin
                    $display("ERR %0t: retire %0d pc %h, expected %h",
                             $time, retired, retire_pc, exp_pc[retired]);
                    err_retire++;
                end
                assert (retire_rd == exp_rd[retired]) else begin
                    $display("ERR %0t: retire %0d pc %h rd %0d, expected %0d",
                             $time, retired, retire_pc, retire_rd, exp_rd[retired]);
                    err_retire++;
                end
                assert (retire_wdata == exp_wdata[retired]) else begin
                    $display("ERR %0t: retire %0d pc %h wdata %h, expected %h",
                             $time, retired, retire_pc, retire_wdata, exp_wdata[retired]);
                    err_retire++;
                end
            end
            retired++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the core did not halt within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // program loop
    initial begin
        int len;
        int n_exp;
        rst        = 1'b1;
        rng_state  = 32'd48811;
        retired    = 0;
        err_retire = 0;
        err_mem    = 0;
        err_other  = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            rst = 1'b1;
            len = build_program();
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i]       = 32'hA5A5_0000 ^ (32'(i) * 32'h0001_0003);
                model_dmem[i] = 32'hA5A5_0000 ^ (32'(i) * 32'h0001_0003);
            end
            n_exp   = run_model();
            retired = 0;
            repeat (5) @(posedge clk);
            #10 rst = 1'b0;
            do begin
                @(posedge clk);
                #10;
            end while (!halt);
            repeat (3) @(posedge clk);  // watch for stray retires
            #10;
            assert (halt) else begin
                $display("halt dropped after program %0d ended", p);
                err_other++;
            end
            assert (retired == n_exp) else begin
                $display("ERR %0t: program %0d of %0d words retired %0d, expected %0d",
                         $time, p, len, retired, n_exp);
                err_retire++;
            end
            for (int i = 0; i < DMEM_WORDS; i++) begin
                assert (dmem[i] == model_dmem[i]) else begin
                    $display("ERR %0t: program %0d dmem[%0d] %h, expected %h",
                             $time, p, i, dmem[i], model_dmem[i]);
                    err_mem++;
                end
            end
        end
        $display("errors: %0d retire, %0d memory, %0d other", err_retire, err_mem, err_other);
        if (err_retire + err_mem + err_other == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
